// File: files.f
+incdir+bench
src/spi2gpio_pkg.sv
src/spi_frontend.sv
src/spi_shifter.sv
src/spi_cmd_ctrl.sv
src/gpio_bank.sv
src/gpio_readback.sv
src/spi2gpio.sv
bench/tb_spi2gpio.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_spi2gpio -o tb_sim \
	|| { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/tb_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1

// File: bench/tb_spi_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host side spi mode 0 tasks, included inside tb_spi2gpio
// timing assumes 4 clk per sclk half period, 8 clk between bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// compare and stop on the first difference
task automatic check(input string what, input logic [15:0] expected, input logic [15:0] actual);
	if (expected !== actual) begin
		$display("MISMATCH test %s, %s: expected %h actual %h",
			test_name, what, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first mismatch");
	end
endtask

// inputs move 1 ns after the edge, outputs are settled by then
task automatic tick(input int n);
	repeat (n) begin
		@(posedge clk);
		#1;
		// miso driver enable tracks cs on every cycle
		check("miso enable", {15'd0, ~spi_cs_n}, {15'd0, spi_miso_en});
	end
endtask

// poll one port's drive, 5 clk at most
task automatic wait_gpio(input int p, input spi2gpio_pkg::gpio_drive_t expected);
	int n;
	n = 0;
	while (gpio_out[p] !== expected && n < 5) begin
		tick(1);
		n++;
	end
	check($sformatf("o_gpio port %0d", p), expected, gpio_out[p]);
endtask

task automatic select_slave();
	spi_cs_n = 1'b0;
	// let the select pulse pass the synchronizer
	tick(4);
endtask

task automatic release_slave();
	spi_cs_n = 1'b1;
	tick(8);
endtask

// one byte, msb first, miso sampled just before each rise
task automatic shift_byte(input spi2gpio_pkg::byte_t tx, output spi2gpio_pkg::byte_t rx);
	for (int i = 7; i >= 0; i--) begin
		spi_sclk = 1'b0;
		spi_mosi = tx[i];
		tick(4);
		rx[i] = spi_miso;
		spi_sclk = 1'b1;
		tick(4);
	end
	spi_sclk = 1'b0;
	// gap between bytes
	tick(8);
endtask

task automatic host_write(input spi2gpio_pkg::addr_t addr, input spi2gpio_pkg::byte_t data);
	spi2gpio_pkg::byte_t rx;
	select_slave();
	shift_byte({2'b10, addr}, rx);
	check("write command response", {8'h00, dummy_byte}, {8'h00, rx});
	shift_byte(data, rx);
	release_slave();
endtask

// read, then one more command byte to see the dummy again
task automatic host_read(input spi2gpio_pkg::addr_t addr, output spi2gpio_pkg::byte_t data);
	spi2gpio_pkg::byte_t rx;
	select_slave();
	shift_byte({2'b00, addr}, rx);
	check("read command response", {8'h00, dummy_byte}, {8'h00, rx});
	shift_byte(8'h00, data);
	// write command with no data byte, nothing gets written
	shift_byte({2'b10, 6'h3F}, rx);
	check("command after read data", {8'h00, dummy_byte}, {8'h00, rx});
	release_slave();
endtask

`endif

// File: bench/tb_spi2gpio.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for the spi to gpio bridge, 4 ports
// gpio inputs are free values, not looped back from the outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_spi2gpio;

	localparam int num_ports = 4;
	// value sent on command bytes
	localparam spi2gpio_pkg::byte_t dummy_byte = 8'h5A;

	logic clk;
	logic rst_n;
	logic spi_sclk;
	logic spi_cs_n;
	logic spi_mosi;
	logic spi_miso;
	logic spi_miso_en;
	spi2gpio_pkg::byte_t [num_ports-1:0] gpio_in;
	spi2gpio_pkg::gpio_drive_t [num_ports-1:0] gpio_out;
	// expected drive of every port
	spi2gpio_pkg::gpio_drive_t [num_ports-1:0] exp_drive;
	string test_name;
	int seed;

	`include "tb_spi_tasks.svh"

	spi2gpio #(.num_ports(num_ports)) dut_i (
		.clk(clk), .rst_n(rst_n),
		.i_spi_sclk(spi_sclk), .i_spi_cs_n(spi_cs_n), .i_spi_mosi(spi_mosi),
		.i_gpio_in(gpio_in),
		.o_spi_miso(spi_miso), .o_spi_miso_en(spi_miso_en), .o_gpio(gpio_out)
	);

	always #20 clk = ~clk;

	function automatic spi2gpio_pkg::byte_t next_random_byte();
		return spi2gpio_pkg::byte_t'($random(seed));
	endfunction

	// register map: 4 addresses per port, oe, out, pins, hole
	function automatic spi2gpio_pkg::byte_t expected_read(input spi2gpio_pkg::addr_t addr);
		int p;
		int off;
		p = int'(addr) / 4;
		off = int'(addr) % 4;
		if (p >= num_ports)
			return 8'h00;
		case (off)
		0: return exp_drive[p].oe;
		1: return exp_drive[p].out;
		2: return gpio_in[p];
		default: return 8'h00;
		endcase
	endfunction

	// update the model, write over spi, then compare every port
	task automatic write_reg(input spi2gpio_pkg::addr_t addr, input spi2gpio_pkg::byte_t data);
		int p;
		int off;
		p = int'(addr) / 4;
		off = int'(addr) % 4;
		if (p < num_ports) begin
			if (off == 0)
				exp_drive[p].oe = data;
			if (off == 1)
				exp_drive[p].out = data;
		end
		host_write(addr, data);
		for (int q = 0; q < num_ports; q++)
			wait_gpio(q, exp_drive[q]);
	endtask

	task automatic read_reg(input spi2gpio_pkg::addr_t addr);
		spi2gpio_pkg::byte_t data;
		host_read(addr, data);
		check($sformatf("read of address %0d", addr), {8'h00, expected_read(addr)}, {8'h00, data});
	endtask

	task automatic reset_values();
		spi2gpio_pkg::byte_t rx;
		test_name = "reset_values";
		for (int p = 0; p < num_ports; p++)
			wait_gpio(p, exp_drive[p]);
		// shifter comes out of reset holding the dummy
		select_slave();
		shift_byte({2'b10, 6'h3F}, rx);
		check("first byte out", {8'h00, dummy_byte}, {8'h00, rx});
		release_slave();
	endtask

	task automatic random_writes();
		test_name = "random_writes";
		for (int p = 0; p < num_ports; p++) begin
			write_reg(spi2gpio_pkg::addr_t'(4 * p), next_random_byte());
			write_reg(spi2gpio_pkg::addr_t'(4 * p + 1), next_random_byte());
		end
	endtask

	task automatic register_readback();
		test_name = "register_readback";
		for (int p = 0; p < num_ports; p++)
			gpio_in[p] = next_random_byte();
		for (int p = 0; p < num_ports; p++) begin
			read_reg(spi2gpio_pkg::addr_t'(4 * p));
			read_reg(spi2gpio_pkg::addr_t'(4 * p + 1));
			read_reg(spi2gpio_pkg::addr_t'(4 * p + 2));
		end
	endtask

	task automatic ignored_accesses();
		test_name = "ignored_accesses";
		// pin input and hole of each port
		for (int p = 0; p < num_ports; p++) begin
			write_reg(spi2gpio_pkg::addr_t'(4 * p + 2), next_random_byte());
			write_reg(spi2gpio_pkg::addr_t'(4 * p + 3), next_random_byte());
		end
		// beyond the last port
		write_reg(6'd16, next_random_byte());
		write_reg(6'd40, next_random_byte());
		write_reg(6'd63, next_random_byte());
		read_reg(6'd3);
		read_reg(6'd16);
		read_reg(6'd63);
	endtask

	// a stray data byte would land 0x84 in port 0 out
	task automatic deselect_restart();
		spi2gpio_pkg::byte_t rx;
		test_name = "deselect_restart";
		select_slave();
		shift_byte({2'b10, 6'd1}, rx);
		release_slave();
		write_reg(6'd4, 8'hC3);
	endtask

	// enable itself is compared inside tick
	task automatic miso_enable_follow();
		test_name = "miso_enable_follow";
		repeat (3) begin
			spi_cs_n = 1'b0;
			tick(3);
			spi_cs_n = 1'b1;
			tick(3);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		spi_sclk = 1'b0;
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		gpio_in = '0;
		seed = 32'h6291b143;
		test_name = "reset";
		// status led port comes up at 0x80/0x80
		exp_drive = '0;
		exp_drive[num_ports-1].oe = 8'h80;
		exp_drive[num_ports-1].out = 8'h80;
		tick(4);
		rst_n = 1'b1;
		tick(2);
		reset_values();
		random_writes();
		register_readback();
		ignored_accesses();
		deselect_restart();
		miso_enable_follow();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// run limit, far above the longest test sequence
	initial begin
		#2000000;
		$display("timeout: the test sequence did not finish in time");
		$display("CHECKS FAILED");
		$fatal(1, "simulation timeout");
	end

endmodule

// File: src/spi2gpio.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi slave to gpio bridge, no tristate pads inside
// last port is the status led port, resets to 0x80/0x80
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi2gpio #(
	parameter int num_ports = 4
) (
	input logic clk,
	input logic rst_n,
	input logic i_spi_sclk,
	input logic i_spi_cs_n,
	input logic i_spi_mosi,
	input spi2gpio_pkg::byte_t [num_ports-1:0] i_gpio_in,
	output logic o_spi_miso,
	output logic o_spi_miso_en,
	output spi2gpio_pkg::gpio_drive_t [num_ports-1:0] o_gpio
);

	// frontend pulses and levels
	logic sclk_rise;
	logic select;
	logic deselect;
	logic mosi_s;
	// shifter
	logic byte_done;
	spi2gpio_pkg::byte_t rx_byte;
	// controller
	spi2gpio_pkg::reg_wr_t wr_req;
	spi2gpio_pkg::reg_rd_t rd_req;
	logic data_phase;
	// banks and readback
	spi2gpio_pkg::byte_t [num_ports-1:0] bank_data;
	logic [num_ports-1:0] bank_hit;
	spi2gpio_pkg::byte_t tx_byte;
	logic load;

	spi_frontend u_frontend (
		.clk(clk), .rst_n(rst_n),
		.i_sclk(i_spi_sclk), .i_cs_n(i_spi_cs_n), .i_mosi(i_spi_mosi),
		.o_sclk_rise(sclk_rise), .o_select(select), .o_deselect(deselect),
		.o_cs_active(), .o_mosi_s(mosi_s)
	);

	// sclk_rise and select both come gated by chip select
	spi_shifter u_shifter (
		.clk(clk), .rst_n(rst_n),
		.i_sclk_rise(sclk_rise), .i_select(select), .i_mosi_s(mosi_s),
		.i_load(load), .i_tx_byte(tx_byte),
		.o_byte_done(byte_done), .o_rx_byte(rx_byte), .o_miso(o_spi_miso)
	);

	spi_cmd_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.i_byte_done(byte_done), .i_rx_byte(rx_byte), .i_deselect(deselect),
		.o_wr_req(wr_req), .o_rd_req(rd_req), .o_data_phase(data_phase)
	);

	for (genvar p = 0; p < num_ports; p++) begin : g_bank
		// status led port comes up driven high on bit 7
		localparam spi2gpio_pkg::byte_t rst_val = (p == num_ports - 1) ? 8'h80 : 8'h00;

		gpio_bank #(.port_index(p), .reset_oe(rst_val), .reset_out(rst_val)) u_bank (
			.clk(clk), .rst_n(rst_n),
			.i_wr_req(wr_req), .i_rd_addr(rd_req.addr), .i_pin_in(i_gpio_in[p]),
			.o_drive(o_gpio[p]), .o_rd_data(bank_data[p]), .o_rd_hit(bank_hit[p])
		);
	end

	gpio_readback #(.num_ports(num_ports)) u_readback (
		.clk(clk), .rst_n(rst_n),
		.i_byte_done(byte_done), .i_rd_req(rd_req), .i_data_phase(data_phase),
		.i_bank_data(bank_data), .i_bank_hit(bank_hit),
		.o_tx_byte(tx_byte), .o_load(load)
	);

	// miso driver enable straight from the pin
	assign o_spi_miso_en = ~i_spi_cs_n;

endmodule

// File: src/gpio_readback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// at most one bank hits, no hit reads as 0
// after a write command the previous tx byte is resent
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gpio_readback #(
	parameter int num_ports = 4
) (
	input logic clk,
	input logic rst_n,
	input logic i_byte_done,
	input spi2gpio_pkg::reg_rd_t i_rd_req,
	input logic i_data_phase,
	input spi2gpio_pkg::byte_t [num_ports-1:0] i_bank_data,
	input logic [num_ports-1:0] i_bank_hit,
	output spi2gpio_pkg::byte_t o_tx_byte,
	output logic o_load
);

	spi2gpio_pkg::byte_t sel_data;
	spi2gpio_pkg::byte_t tx_byte;
	logic load;

	// and-or mux over the one-hot hits
	always_comb begin
		sel_data = '0;
		for (int p = 0; p < num_ports; p++) begin
			sel_data = sel_data | (i_bank_data[p] & {spi2gpio_pkg::port_w{i_bank_hit[p]}});
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_byte <= spi2gpio_pkg::spi_dummy;
			load <= 1'b0;
		end else begin
			// shifter takes tx_byte one cycle later
			load <= i_byte_done;
			if (i_rd_req.strobe)
				tx_byte <= sel_data;
			else if (i_byte_done && i_data_phase)
				tx_byte <= spi2gpio_pkg::spi_dummy;
		end
	end

	assign o_tx_byte = tx_byte;
	assign o_load = load;

endmodule

// File: src/gpio_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one 8-bit port at addresses 4*port_index .. +2
// the input register is read only, pins are not synchronized
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gpio_bank #(
	parameter int port_index = 0,
	parameter spi2gpio_pkg::byte_t reset_oe = 8'h00,
	parameter spi2gpio_pkg::byte_t reset_out = 8'h00
) (
	input logic clk,
	input logic rst_n,
	input spi2gpio_pkg::reg_wr_t i_wr_req,
	input spi2gpio_pkg::addr_t i_rd_addr,
	input spi2gpio_pkg::byte_t i_pin_in,
	output spi2gpio_pkg::gpio_drive_t o_drive,
	output spi2gpio_pkg::byte_t o_rd_data,
	output logic o_rd_hit
);

	// first address of this port's window
	localparam spi2gpio_pkg::addr_t base =
		spi2gpio_pkg::addr_t'(port_index * spi2gpio_pkg::port_stride);

	spi2gpio_pkg::addr_t wr_off;
	spi2gpio_pkg::addr_t rd_off;
	logic wr_win;
	logic rd_win;
	spi2gpio_pkg::gpio_drive_t drive;

	assign wr_off = i_wr_req.addr - base;
	assign rd_off = i_rd_addr - base;
	assign wr_win = (i_wr_req.addr >= base) && (wr_off < spi2gpio_pkg::port_stride);
	assign rd_win = (i_rd_addr >= base) && (rd_off < spi2gpio_pkg::port_stride);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drive.oe <= reset_oe;
			drive.out <= reset_out;
		end else if (i_wr_req.strobe && wr_win) begin
			// writes to the input offset fall through
			if (wr_off == spi2gpio_pkg::off_oe)
				drive.oe <= i_wr_req.data;
			else if (wr_off == spi2gpio_pkg::off_out)
				drive.out <= i_wr_req.data;
		end
	end

	assign o_drive = drive;

	always_comb begin
		o_rd_data = '0;
		o_rd_hit = 1'b0;
		if (rd_win) begin
			o_rd_hit = 1'b1;
			case (rd_off)
			spi2gpio_pkg::off_oe: o_rd_data = drive.oe;
			spi2gpio_pkg::off_out: o_rd_data = drive.out;
			spi2gpio_pkg::off_in: o_rd_data = i_pin_in;
			// hole at offset 3
			default: o_rd_hit = 1'b0;
			endcase
		end
	end

endmodule

// File: src/spi_cmd_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command/data byte pairing, deselect restarts at a command
// read request is combinational in the byte_done cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi_cmd_ctrl (
	input logic clk,
	input logic rst_n,
	input logic i_byte_done,
	input spi2gpio_pkg::byte_t i_rx_byte,
	input logic i_deselect,
	output spi2gpio_pkg::reg_wr_t o_wr_req,
	output spi2gpio_pkg::reg_rd_t o_rd_req,
	output logic o_data_phase
);

	// 0 while waiting for a command byte
	logic data_phase;
	// latched from the command byte
	logic wr_flag;
	spi2gpio_pkg::addr_t wr_addr;
	logic wr_strobe;
	spi2gpio_pkg::byte_t wr_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_phase <= 1'b0;
			wr_flag <= 1'b0;
			wr_addr <= '0;
			wr_strobe <= 1'b0;
		end else begin
			wr_strobe <= 1'b0;
			if (i_deselect) begin
				data_phase <= 1'b0;
			end else if (i_byte_done) begin
				if (!data_phase) begin
					// command byte
					wr_flag <= i_rx_byte[spi2gpio_pkg::wr_flag_bit];
					wr_addr <= i_rx_byte[spi2gpio_pkg::addr_w-1:0];
					data_phase <= 1'b1;
				end else begin
					// data byte, write only if the command asked for it
					wr_strobe <= wr_flag;
					data_phase <= 1'b0;
				end
			end
		end
	end

	// payload copy, the shifter reloads right after
	always_ff @(posedge clk) begin
		if (i_byte_done && data_phase) begin
			wr_data <= i_rx_byte;
		end
	end

	assign o_wr_req.strobe = wr_strobe;
	assign o_wr_req.addr = wr_addr;
	assign o_wr_req.data = wr_data;

	// read of the address just received, answered before the load
	assign o_rd_req.strobe = i_byte_done & ~data_phase &
		~i_rx_byte[spi2gpio_pkg::wr_flag_bit];
	assign o_rd_req.addr = i_rx_byte[spi2gpio_pkg::addr_w-1:0];

	assign o_data_phase = data_phase;

endmodule

// File: src/spi_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mode 0 byte shifter, msb first in both directions
// one register serves rx and tx, a load overwrites the rx byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi_shifter (
	input logic clk,
	input logic rst_n,
	input logic i_sclk_rise,
	input logic i_select,
	input logic i_mosi_s,
	input logic i_load,
	input spi2gpio_pkg::byte_t i_tx_byte,
	output logic o_byte_done,
	output spi2gpio_pkg::byte_t o_rx_byte,
	output logic o_miso
);

	// one-hot bit counter, bit 8 is the overflow
	logic [8:0] bit_cnt;
	spi2gpio_pkg::byte_t shift_r;

	// counter restarts on select, on load and on its own overflow
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= 9'd1;
		end else if (i_select || i_load || bit_cnt[8]) begin
			bit_cnt <= 9'd1;
		end else if (i_sclk_rise) begin
			bit_cnt <= {bit_cnt[7:0], 1'b0};
		end
	end

	// overflow bit is high for exactly one cycle
	assign o_byte_done = bit_cnt[8];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// first byte out after reset is the dummy
			shift_r <= spi2gpio_pkg::spi_dummy;
		end else if (i_load) begin
			shift_r <= i_tx_byte;
		end else if (i_sclk_rise) begin
			// mosi enters at lsb, next tx bit moves up to msb
			shift_r <= {shift_r[6:0], i_mosi_s};
		end
	end

	// valid in the byte_done cycle and the one after
	assign o_rx_byte = shift_r;
	// msb changes after a rising edge, master samples before the next
	assign o_miso = shift_r[7];

endmodule

// File: src/spi_frontend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi pins brought into clk, one flop each plus one for edges
// sclk needs a half period of at least 4 clk cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi_frontend (
	input logic clk,
	input logic rst_n,
	input logic i_sclk,
	input logic i_cs_n,
	input logic i_mosi,
	output logic o_sclk_rise,
	output logic o_select,
	output logic o_deselect,
	output logic o_cs_active,
	output logic o_mosi_s
);

	// first stage, sampled pins
	logic sclk_r;
	logic cs_n_r;
	logic mosi_r;
	// second stage, previous samples for edge detect
	logic sclk_l;
	logic cs_n_l;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_r <= 1'b0;
			cs_n_r <= 1'b1;
			mosi_r <= 1'b0;
			sclk_l <= 1'b0;
			cs_n_l <= 1'b1;
		end else begin
			sclk_r <= i_sclk;
			cs_n_r <= i_cs_n;
			mosi_r <= i_mosi;
			sclk_l <= sclk_r;
			cs_n_l <= cs_n_r;
		end
	end

	// rising sclk only counts while selected
	assign o_sclk_rise = sclk_r & ~sclk_l & ~cs_n_r;
	// cs falling edge, start of a transaction
	assign o_select = ~cs_n_r & cs_n_l;
	// cs rising edge, back to command phase
	assign o_deselect = cs_n_r & ~cs_n_l;
	assign o_cs_active = ~cs_n_r;
	assign o_mosi_s = mosi_r;

endmodule

// File: src/spi2gpio_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, register map offsets and request structs
// every port owns a 4-address window, offsets 3 and up read as 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi2gpio_pkg;

	// one port, one register, one spi byte
	localparam int port_w = 8;
	// 64 register addresses
	localparam int addr_w = 6;

	typedef logic [port_w-1:0] byte_t;
	typedef logic [addr_w-1:0] addr_t;

	// register offsets inside a port window
	localparam addr_t off_oe = 6'd0;
	localparam addr_t off_out = 6'd1;
	localparam addr_t off_in = 6'd2;
	localparam int port_stride = 4;

	// sent during command bytes and right after reset
	localparam byte_t spi_dummy = 8'h5A;

	// command byte layout: bit 7 write, bit 6 unused, bits 5:0 address
	localparam int wr_flag_bit = 7;

	// register write request, strobe is one clk wide
	typedef struct packed {
		logic strobe;
		addr_t addr;
		byte_t data;
	} reg_wr_t;

	// register read request, answered in the same cycle by the banks
	typedef struct packed {
		logic strobe;
		addr_t addr;
	} reg_rd_t;

	// drive of one port, a pin is driven where oe is set
	typedef struct packed {
		byte_t oe;
		byte_t out;
	} gpio_drive_t;

endpackage
